//--- verilog.f
+incdir+common
common/i2c_pkg.sv
common/eeprom_pkg.sv
common/i2c_byte_if.sv
src/scl_timer.sv
i2c/i2c_byte_engine.sv
i2c/i2c_sequencer.sv
src/i2c_eeprom_master.sv
test/eeprom_slave_model.sv
test/tb_i2c_eeprom_master.sv

//--- Bender.yml
package:
  name: i2c_eeprom_master

sources:
  - include_dirs:
      - common
    files:
      - common/i2c_pkg.sv
      - common/eeprom_pkg.sv
      - common/i2c_byte_if.sv
      - src/scl_timer.sv
      - i2c/i2c_byte_engine.sv
      - i2c/i2c_sequencer.sv
      - src/i2c_eeprom_master.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/eeprom_slave_model.sv
      - test/tb_i2c_eeprom_master.sv

//--- test/tb_i2c_eeprom_master.sv
`timescale 1ns/1ps
`include "i2c_defines.svh"

module tb_i2c_eeprom_master
    import eeprom_pkg::*;
();
    localparam int         DIV        = 20;
    localparam int         N_TESTS    = 5;
    // tests x longest transaction in bytes x scl periods per byte x divider
    localparam int         MAX_CYCLES = N_TESTS * 40 * 9 * DIV;
    localparam logic [2:0] SLAVE_CHIP = 3'b010;

    logic        sys_clk;
    logic        Rst_n;
    logic [2:0]  device_addr;
    logic [15:0] word_addr;
    addr_len_t   word_addr_len;
    logic        wr_en;
    logic        rd_en;
    logic [7:0]  wr_data;
    byte_cnt_t   wr_data_long;
    logic        wr_data_done;
    logic        rd_data_done;
    logic [7:0]  rd_data_out;
    logic        iic_busy_done;
    logic        nack_err;
    logic        iic_scl;
    wire         iic_sda;
    logic        slave_addr2;

    logic [7:0]  ref_mem [0:65535];
    logic [7:0]  wbuf [0:63];
    logic [7:0]  exp_byte = '0;
    integer      seed;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cmd_cnt = 0;
    int          busy_cnt = 0;
    int          wr_done_cnt = 0;
    int          rd_done_cnt = 0;
    int          proto_err = 0;
    int          scl_rises = 0;
    int          cycles = 0;

    pullup (iic_sda);

    i2c_eeprom_master #(
        .SYS_CLOCK (`I2C_SYS_CLOCK),
        .SCL_CLOCK (`I2C_SYS_CLOCK / DIV)
    ) i_dut (.*);

    eeprom_slave_model #(.DEV_ADDR(SLAVE_CHIP)) i_slave (
        .scl   (iic_scl),
        .sda   (iic_sda),
        .addr2 (slave_addr2)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #5 sys_clk = !sys_clk;
    end

    always @(posedge sys_clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] ref_read(input logic [15:0] addr);
        return ref_mem[addr];
    endfunction

    // a 1-byte address reaches only the lowest 256 locations
    function automatic logic [15:0] eff_addr(input logic [15:0] addr, input addr_len_t alen);
        return (alen == 2'd2) ? addr : {8'h00, addr[7:0]};
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input byte_cnt_t got, input byte_cnt_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic send_command(input logic [2:0] chip, input logic [15:0] addr,
                                input addr_len_t alen, input logic wr);
        device_addr   = chip;
        word_addr     = addr;
        word_addr_len = alen;
        slave_addr2   = (alen == 2'd2);
        wr_en         = wr;
        rd_en         = !wr;
        cmd_cnt++;
        @(negedge sys_clk);
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic write_burst(input logic [2:0] chip, input logic [15:0] addr,
                               input addr_len_t alen, input byte_cnt_t len);
        int idx;
        idx          = 0;
        wr_data      = wbuf[0];
        wr_data_long = len;
        send_command(chip, addr, alen, 1'b1);
        while (!iic_busy_done)
        begin
            if (wr_data_done)
            begin
                idx++;
                wr_data = wbuf[idx];  // next byte before the next load
            end
            @(negedge sys_clk);
        end
        if (chip == SLAVE_CHIP)
            for (int i = 0; i < len; i++)
                ref_mem[eff_addr(addr, alen) + 16'(i)] = wbuf[i];
    endtask

    task automatic read_byte(input logic [2:0] chip, input logic [15:0] addr,
                             input addr_len_t alen);
        exp_byte = ref_read(eff_addr(addr, alen));
        send_command(chip, addr, alen, 1'b0);
        while (!iic_busy_done)
            @(negedge sys_clk);
    endtask

    // done pulses counted mid-cycle, read data compared against the reference
    always @(negedge sys_clk)
        if (Rst_n)
        begin
            if (iic_busy_done)
                busy_cnt++;
            if (wr_data_done)
                wr_done_cnt++;
            if (rd_data_done)
            begin
                rd_done_cnt++;
                check_byte(rd_data_out, exp_byte, "rd_data_out");
            end
        end

    always @(posedge iic_scl)
        if (Rst_n === 1'b1)
            scl_rises++;

    // with scl high sda may move only at a start, repeated start or stop
    always @(iic_sda)
        if (Rst_n === 1'b1 && iic_scl === 1'b1)
        begin
            if (!(scl_rises == 0 || (scl_rises > 1 && scl_rises % 9 == 1)))
            begin
                proto_err++;
                $display("protocol violation at %0t ns: SDA changed with SCL high inside a byte",
                         $time);
            end
            scl_rises = 0;
        end

    initial
    begin
        logic [15:0] a;
        byte_cnt_t   n;
        int          rd_mark;
        int          wr_mark;
        seed          = 32'hc520;
        Rst_n         = 1'b0;
        device_addr   = '0;
        word_addr     = '0;
        word_addr_len = 2'd1;
        wr_en         = 1'b0;
        rd_en         = 1'b0;
        wr_data       = '0;
        wr_data_long  = 6'd1;
        slave_addr2   = 1'b0;
        for (int i = 0; i < 65536; i++)
            ref_mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;  // same fill as the slave
        repeat (10) @(negedge sys_clk);
        Rst_n = 1'b1;

        repeat (20) @(negedge sys_clk);
        check_flag(iic_scl, 1'b1, "iic_scl idle");
        check_flag(iic_sda, 1'b1, "iic_sda idle");
        check_flag(nack_err, 1'b0, "nack_err after reset");
        check_count(byte_cnt_t'(busy_cnt + wr_done_cnt + rd_done_cnt), '0, "done pulses");
        finish_test("1 reset");

        a       = {8'h00, 8'($random(seed))};
        wbuf[0] = 8'($random(seed));
        write_burst(SLAVE_CHIP, a, 2'd1, 6'd1);
        rd_mark = rd_done_cnt;
        read_byte(SLAVE_CHIP, a, 2'd1);
        check_count(byte_cnt_t'(rd_done_cnt - rd_mark), 6'd1, "rd_data_done pulses");
        finish_test("2 single write and read");

        n = byte_cnt_t'(2 + $unsigned($random(seed)) % 7);
        a = 16'($random(seed));
        for (int i = 0; i < n; i++)
            wbuf[i] = 8'($random(seed));
        wr_mark = wr_done_cnt;
        write_burst(SLAVE_CHIP, a, 2'd2, n);
        check_count(byte_cnt_t'(wr_done_cnt - wr_mark), n, "wr_data_done pulses");
        for (int i = 0; i < n; i++)
            read_byte(SLAVE_CHIP, a + 16'(i), 2'd2);
        finish_test("3 burst write");

        a       = 16'($random(seed));
        wbuf[0] = ~ref_read(a);  // a lost write would show up on read back
        wbuf[1] = 8'($random(seed));
        wr_mark = wr_done_cnt;
        write_burst(3'b011, a, 2'd2, 6'd2);
        check_flag(nack_err, 1'b1, "nack_err with no slave");
        check_count(byte_cnt_t'(wr_done_cnt - wr_mark), '0, "wr_data_done after nack");
        read_byte(SLAVE_CHIP, a, 2'd2);
        check_flag(nack_err, 1'b0, "nack_err after good read");
        finish_test("4 slave nack");

        repeat (20) @(negedge sys_clk);
        check_count(byte_cnt_t'(busy_cnt), byte_cnt_t'(cmd_cnt), "iic_busy_done pulses");
        check_flag(proto_err == 0, 1'b1, "bus free of protocol violations");
        finish_test("5 protocol");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end
endmodule

//--- test/eeprom_slave_model.sv
`timescale 1ns/1ps

module eeprom_slave_model #(
    parameter logic [2:0] DEV_ADDR = 3'b010
) (
    input  logic scl,
    inout  wire  sda,
    input  logic addr2        // word address is two bytes
);
    localparam int S_IDLE = 0;
    localparam int S_CTRL = 1;
    localparam int S_AH   = 2;
    localparam int S_AL   = 3;
    localparam int S_WR   = 4;
    localparam int S_RD   = 5;

    logic [7:0]  mem [0:65535];
    logic [15:0] ptr     = '0;
    logic [7:0]  sh      = '0;
    logic [7:0]  rd_byte = '0;
    logic        sda_drv = 1'b0;  // 1 pulls sda low
    logic        mnack   = 1'b0;
    int          st      = S_IDLE;
    int          bit_cnt = 0;

    assign sda = sda_drv ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
    end

    // start or repeated start
    always @(negedge sda)
        if (scl === 1'b1)
        begin
            st      = S_CTRL;
            bit_cnt = 0;
            sda_drv = 1'b0;
        end

    always @(posedge sda)
        if (scl === 1'b1)
        begin
            st      = S_IDLE;   // stop
            sda_drv = 1'b0;
        end

    always @(posedge scl)
        if (st != S_IDLE)
        begin
            if (bit_cnt < 8)
                sh = {sh[6:0], sda !== 1'b0};
            else if (st == S_RD)
                mnack = (sda !== 1'b0);  // master ack bit
            bit_cnt = bit_cnt + 1;
        end

    always @(negedge scl)
        if (st == S_IDLE)
            sda_drv = 1'b0;
        else if (bit_cnt == 8 && st != S_RD)
        begin
            sda_drv = 1'b1;  // ack the byte just received
            case (st)
                S_CTRL:
                    if (sh[7:1] != {4'b1010, DEV_ADDR})
                    begin
                        sda_drv = 1'b0;  // not our chip
                        st      = S_IDLE;
                    end
                    else if (sh[0])
                    begin
                        st    = S_RD;
                        mnack = 1'b0;
                    end
                    else
                        st = addr2 ? S_AH : S_AL;
                S_AH:
                begin
                    ptr[15:8] = sh;
                    st        = S_AL;
                end
                S_AL:
                begin
                    ptr = {addr2 ? ptr[15:8] : 8'h00, sh};
                    st  = S_WR;
                end
                default:
                begin
                    mem[ptr] = sh;
                    ptr      = ptr + 1'b1;
                end
            endcase
        end
        else if (bit_cnt == 8)
            sda_drv = 1'b0;
        else if (bit_cnt == 9)
        begin
            bit_cnt = 0;
            sda_drv = 1'b0;
            if (st == S_RD && mnack)
                st = S_IDLE;
            else if (st == S_RD)
            begin
                rd_byte = mem[ptr];
                ptr     = ptr + 1'b1;
                sda_drv = !rd_byte[7];
            end
        end
        else if (st == S_RD)
            sda_drv = !rd_byte[7 - bit_cnt];
endmodule

//--- src/i2c_eeprom_master.sv
`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_eeprom_master
    import eeprom_pkg::*;
#(
    parameter int SYS_CLOCK = `I2C_SYS_CLOCK,
    parameter int SCL_CLOCK = `I2C_SCL_CLOCK
) (
    input  logic        sys_clk,
    input  logic        Rst_n,
    input  logic [2:0]  device_addr,
    input  logic [15:0] word_addr,
    input  addr_len_t   word_addr_len,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic [7:0]  wr_data,
    input  byte_cnt_t   wr_data_long,
    output logic        wr_data_done,
    output logic        rd_data_done,
    output logic [7:0]  rd_data_out,
    output logic        iic_busy_done,
    output logic        nack_err,
    output logic        iic_scl,
    inout  wire         iic_sda
);
    logic run;
    logic scl_high_mid;
    logic scl_low_mid;
    logic eng_oe;
    logic eng_out;
    logic seq_oe;
    logic seq_out;
    logic sda_low;

    i2c_byte_if bus_if ();

    scl_timer #(
        .SYS_CLOCK (SYS_CLOCK),
        .SCL_CLOCK (SCL_CLOCK)
    ) i_scl_timer (
        .sys_clk      (sys_clk),
        .Rst_n        (Rst_n),
        .run          (run),
        .iic_scl      (iic_scl),
        .scl_high_mid (scl_high_mid),
        .scl_low_mid  (scl_low_mid)
    );

    i2c_byte_engine i_byte_engine (
        .sys_clk      (sys_clk),
        .Rst_n        (Rst_n),
        .scl_high_mid (scl_high_mid),
        .scl_low_mid  (scl_low_mid),
        .sda_in       (iic_sda),
        .bus          (bus_if.slave),
        .sda_oe       (eng_oe),
        .sda_out      (eng_out)
    );

    i2c_sequencer i_sequencer (
        .sys_clk       (sys_clk),
        .Rst_n         (Rst_n),
        .scl_high_mid  (scl_high_mid),
        .scl_low_mid   (scl_low_mid),
        .device_addr   (device_addr),
        .word_addr     (word_addr),
        .word_addr_len (word_addr_len),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .wr_data       (wr_data),
        .wr_data_long  (wr_data_long),
        .bus           (bus_if.master),
        .run           (run),
        .sda_oe        (seq_oe),
        .sda_out       (seq_out),
        .wr_data_done  (wr_data_done),
        .rd_data_done  (rd_data_done),
        .rd_data_out   (rd_data_out),
        .iic_busy_done (iic_busy_done),
        .nack_err      (nack_err)
    );

    // open drain, only ever pull low
    assign sda_low = (eng_oe && !eng_out) || (seq_oe && !seq_out);
    assign iic_sda = sda_low ? 1'b0 : 1'bz;
endmodule

//--- i2c/i2c_sequencer.sv
`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_sequencer
    import i2c_pkg::*, eeprom_pkg::*;
(
    input  logic        sys_clk,
    input  logic        Rst_n,
    input  logic        scl_high_mid,
    input  logic        scl_low_mid,
    input  logic [2:0]  device_addr,
    input  logic [15:0] word_addr,
    input  addr_len_t   word_addr_len,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic [7:0]  wr_data,
    input  byte_cnt_t   wr_data_long,
    i2c_byte_if.master  bus,
    output logic        run,
    output logic        sda_oe,
    output logic        sda_out,
    output logic        wr_data_done,
    output logic        rd_data_done,
    output logic [7:0]  rd_data_out,
    output logic        iic_busy_done,
    output logic        nack_err
);
    seq_state_t  state;
    logic        rd_op;
    addr_len_t   addr_cnt;      // address bytes sent
    byte_cnt_t   wr_cnt;
    logic        rd_pend;
    logic [2:0]  dev_q;
    logic [15:0] waddr_q;
    addr_len_t   alen_q;
    byte_cnt_t   wlen_q;
    ctrl_byte_u  ctrl;

    always_comb
    begin
        ctrl.f.dev_type = `I2C_DEV_TYPE;
        ctrl.f.chip     = dev_q;
        ctrl.f.rw       = (state == RSTART);
    end

    task load_byte(input logic [7:0] b, input logic rx);
        bus.start       <= 1'b1;
        bus.tx_byte     <= b;
        bus.rx_mode     <= rx;
        bus.master_nack <= rx;  // single read byte is always nacked
    endtask

    // pull sda low while scl is low, released again mid high
    task go_stop;
        state   <= STOP;
        sda_oe  <= 1'b1;
        sda_out <= 1'b0;
    endtask

    always_ff @(posedge sys_clk or negedge Rst_n)
    begin
        if (!Rst_n)
        begin
            state           <= IDLE;
            run             <= 1'b0;
            sda_oe          <= 1'b0;
            sda_out         <= 1'b1;
            rd_op           <= 1'b0;
            addr_cnt        <= '0;
            wr_cnt          <= '0;
            bus.start       <= 1'b0;
            bus.tx_byte     <= 8'hff;
            bus.rx_mode     <= 1'b0;
            bus.master_nack <= 1'b0;
            wr_data_done    <= 1'b0;
            rd_pend         <= 1'b0;
            rd_data_done    <= 1'b0;
            iic_busy_done   <= 1'b0;
            nack_err        <= 1'b0;
        end
        else
        begin
            bus.start     <= 1'b0;
            wr_data_done  <= 1'b0;
            iic_busy_done <= 1'b0;
            rd_pend       <= 1'b0;
            rd_data_done  <= rd_pend;
            case (state)
                IDLE:
                    if (wr_en || rd_en)
                    begin
                        rd_op    <= !wr_en;  // write wins
                        run      <= 1'b1;
                        nack_err <= 1'b0;
                        state    <= START;
                    end
                START, RSTART:
                    if (scl_high_mid && !sda_oe)
                    begin
                        sda_oe  <= 1'b1;     // sda falls with scl high
                        sda_out <= 1'b0;
                    end
                    else if (scl_low_mid && sda_oe)
                    begin
                        sda_oe  <= 1'b0;
                        sda_out <= 1'b1;
                        load_byte(ctrl.raw, 1'b0);
                        state   <= (state == START) ? CTRL : RCTRL;
                    end
                CTRL, WADDR, WDATA, RCTRL, RDATA:
                    if (bus.done)
                    begin
                        if (!bus.ack_ok)
                        begin
                            nack_err <= 1'b1;
                            go_stop();
                        end
                        else
                            case (state)
                                CTRL:
                                begin
                                    addr_cnt <= addr_len_t'(1);
                                    load_byte((alen_q == 2'd2) ? waddr_q[15:8] : waddr_q[7:0],
                                              1'b0);
                                    state    <= WADDR;
                                end
                                WADDR:
                                    if (addr_cnt != alen_q)
                                    begin
                                        addr_cnt <= addr_cnt + 1'b1;
                                        load_byte(waddr_q[7:0], 1'b0);
                                    end
                                    else if (rd_op)
                                        state <= RSTART;
                                    else
                                    begin
                                        load_byte(wr_data, 1'b0);
                                        wr_data_done <= 1'b1;
                                        wr_cnt       <= byte_cnt_t'(1);
                                        state        <= WDATA;
                                    end
                                WDATA:
                                    if (wr_cnt >= wlen_q)
                                        go_stop();
                                    else
                                    begin
                                        load_byte(wr_data, 1'b0);
                                        wr_data_done <= 1'b1;
                                        wr_cnt       <= wr_cnt + 1'b1;
                                    end
                                RCTRL:
                                begin
                                    load_byte(8'hff, 1'b1);
                                    state <= RDATA;
                                end
                                default:     // RDATA
                                begin
                                    rd_pend <= 1'b1;
                                    go_stop();
                                end
                            endcase
                    end
                STOP:
                    if (scl_high_mid)
                    begin
                        sda_oe        <= 1'b0;  // sda rises with scl high
                        sda_out       <= 1'b1;
                        run           <= 1'b0;
                        iic_busy_done <= 1'b1;
                        state         <= IDLE;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (state == IDLE && (wr_en || rd_en))
        begin
            dev_q   <= device_addr;
            waddr_q <= word_addr;
            alen_q  <= word_addr_len;
            wlen_q  <= wr_data_long;
        end
        if (state == RDATA && bus.done)
            rd_data_out <= bus.rx_byte;
    end
endmodule

//--- i2c/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine
    import i2c_pkg::*;
(
    input  logic       sys_clk,
    input  logic       Rst_n,
    input  logic       scl_high_mid,
    input  logic       scl_low_mid,
    input  logic       sda_in,
    i2c_byte_if.slave  bus,
    output logic       sda_oe,
    output logic       sda_out
);
    logic       busy;
    logic       rx;          // latched rx_mode for the current byte
    phase_t     phase;
    logic [7:0] shreg;

    assign bus.rx_byte = shreg;

    always_ff @(posedge sys_clk or negedge Rst_n)
    begin
        if (!Rst_n)
        begin
            busy       <= 1'b0;
            rx         <= 1'b0;
            phase      <= '0;
            sda_oe     <= 1'b0;
            sda_out    <= 1'b1;
            bus.done   <= 1'b0;
            bus.ack_ok <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (bus.start)
            begin
                busy    <= 1'b1;
                rx      <= bus.rx_mode;
                phase   <= '0;
                sda_oe  <= !bus.rx_mode;
                sda_out <= bus.tx_byte[7];  // scl is low here
            end
            else if (busy && scl_high_mid)
            begin
                phase <= phase + 1'b1;
                if (phase == PHASE_ACK)
                    bus.ack_ok <= rx || !sda_in;  // slave pulls low to ack
            end
            else if (busy && scl_low_mid)
            begin
                if (phase == PHASE_LAST)
                begin
                    busy     <= 1'b0;
                    phase    <= '0;
                    sda_oe   <= 1'b0;
                    sda_out  <= 1'b1;
                    bus.done <= 1'b1;
                end
                else
                begin
                    phase <= phase + 1'b1;
                    if (phase == PHASE_ACK - 5'd1)
                    begin
                        // ninth bit, release for slave ack or drive our own
                        sda_oe  <= rx;
                        sda_out <= bus.master_nack;
                    end
                    else
                        sda_out <= shreg[6];
                end
            end
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (bus.start)
            shreg <= bus.tx_byte;
        else if (busy && !rx && scl_low_mid && phase < PHASE_ACK - 5'd1)
            shreg <= {shreg[6:0], 1'b0};
        else if (busy && rx && scl_high_mid && phase < PHASE_ACK)
            shreg <= {shreg[6:0], sda_in};  // sample mid high
    end
endmodule

//--- src/scl_timer.sv
`timescale 1ns/1ps
`include "i2c_defines.svh"

module scl_timer #(
    parameter int SYS_CLOCK = `I2C_SYS_CLOCK,
    parameter int SCL_CLOCK = `I2C_SCL_CLOCK
) (
    input  logic sys_clk,
    input  logic Rst_n,
    input  logic run,
    output logic iic_scl,
    output logic scl_high_mid,
    output logic scl_low_mid
);
    localparam int DIV = SYS_CLOCK / SCL_CLOCK;

    localparam logic [`I2C_CNT_W-1:0] CNT_MAX  = `I2C_CNT_W'(DIV - 1);
    localparam logic [`I2C_CNT_W-1:0] CNT_HALF = `I2C_CNT_W'(DIV / 2);
    localparam logic [`I2C_CNT_W-1:0] CNT_QTR  = `I2C_CNT_W'(DIV / 4);
    localparam logic [`I2C_CNT_W-1:0] CNT_3QTR = `I2C_CNT_W'(DIV / 4 + DIV / 2);

    logic [`I2C_CNT_W-1:0] cnt;

    always_ff @(posedge sys_clk or negedge Rst_n)
    begin
        if (!Rst_n)
            cnt <= '0;
        else if (!run || cnt == CNT_MAX)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // outputs lag cnt by one cycle, strobes stay inside their half
    always_ff @(posedge sys_clk or negedge Rst_n)
    begin
        if (!Rst_n)
        begin
            iic_scl      <= 1'b1;
            scl_high_mid <= 1'b0;
            scl_low_mid  <= 1'b0;
        end
        else
        begin
            iic_scl      <= !run || (cnt < CNT_HALF);  // rests high when idle
            scl_high_mid <= run && (cnt == CNT_QTR);
            scl_low_mid  <= run && (cnt == CNT_3QTR);
        end
    end
endmodule

//--- common/i2c_byte_if.sv
`timescale 1ns/1ps

interface i2c_byte_if;
    logic       start;        // one cycle, engine must be idle
    logic       rx_mode;
    logic [7:0] tx_byte;
    logic       master_nack;
    logic       done;         // one cycle, end of ninth bit
    logic       ack_ok;
    logic [7:0] rx_byte;

    modport master (
        output start, rx_mode, tx_byte, master_nack,
        input  done, ack_ok, rx_byte
    );

    modport slave (
        input  start, rx_mode, tx_byte, master_nack,
        output done, ack_ok, rx_byte
    );
endinterface

//--- common/eeprom_pkg.sv
`include "i2c_defines.svh"

package eeprom_pkg;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL,
        WADDR,
        WDATA,
        RSTART,
        RCTRL,
        RDATA,
        STOP
    } seq_state_t;

    typedef logic [`I2C_ADDR_LEN_W-1:0] addr_len_t;
    typedef logic [`I2C_LEN_W-1:0]      byte_cnt_t;

endpackage

//--- common/i2c_pkg.sv
package i2c_pkg;

    // control byte fields, msb first on the wire
    typedef struct packed {
        logic [3:0] dev_type;
        logic [2:0] chip;
        logic       rw;         // 1 = read
    } ctrl_fields_t;

    typedef union packed {
        logic [7:0]   raw;      // what the shifter sends
        ctrl_fields_t f;
    } ctrl_byte_u;

    // half-bit counter inside one byte slot, 0..17
    typedef logic [4:0] phase_t;

    localparam phase_t PHASE_ACK  = 5'd16;  // high half of the ninth bit
    localparam phase_t PHASE_LAST = 5'd17;  // low half of the ninth bit

endpackage

//--- common/i2c_defines.svh
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// fixed upper nibble of the control byte, serial EEPROM family
`define I2C_DEV_TYPE   4'b1010

`define I2C_CNT_W      16  // scl divider counter
`define I2C_LEN_W      6   // burst write length
`define I2C_ADDR_LEN_W 2   // word address length, 1 or 2 bytes

// default rates
`define I2C_SYS_CLOCK  50_000_000
`define I2C_SCL_CLOCK  400_000

`endif
